/* bench/ucb_asserts.sv */
`timescale 1ns/1ns

module ucb_asserts
   import ucb_pkg::*;
(
   input logic      clk,
   input logic      rst_n,
   input logic      awready,
   input logic      bvalid,
   input logic      bready,
   input ucb_resp_t bresp,
   input logic      rvalid,
   input logic      rready,
   input ucb_data_t rdata,
   input ucb_resp_t rresp,
   input logic      insn_end,
   input ucb_bank_t ucb,
   input logic      irq_inhibit
);

   // Number of failed assertions
   int unsigned error_count = 0;

   ////////////////////////////////////////////////////////////
   // AXI4-Lite response channels
   ////////////////////////////////////////////////////////////

   // Write response waits for bready without changing
   bresp_held: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else begin
         $error("bvalid or bresp changed before bready");
         error_count++;
      end

   // Read data waits for rready without changing
   rdata_held: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
      else begin
         $error("rvalid, rdata or rresp changed before rready");
         error_count++;
      end

   // One transaction in flight
   no_aw_in_wresp: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid |-> !awready)
      else begin
         $error("awready raised while bvalid waits");
         error_count++;
      end

   ////////////////////////////////////////////////////////////
   // Bank pipeline
   ////////////////////////////////////////////////////////////

   // Output bank moves only on an instruction end
   ucb_on_end: assert property (@(posedge clk) disable iff (!rst_n)
      !$stable(ucb) |-> $past(insn_end))
      else begin
         $error("ucb changed without insn_end");
         error_count++;
      end

   inhibit_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !irq_inhibit)
      else begin
         $error("irq_inhibit high out of reset");
         error_count++;
      end

endmodule

bind ucb_top ucb_asserts u_asserts (
   .clk         (clk),
   .rst_n       (rst_n),
   .awready     (awready),
   .bvalid      (bvalid),
   .bready      (bready),
   .bresp       (bresp),
   .rvalid      (rvalid),
   .rready      (rready),
   .rdata       (rdata),
   .rresp       (rresp),
   .insn_end    (insn_end),
   .ucb         (ucb),
   .irq_inhibit (irq_inhibit)
);

/* bench/ucb_stim.txt */
# W addr strb data resp hold | R addr data resp hold | E ucb inh (after an insn_end pulse)
# S ucb inh (no pulse) | C addr data resp ucb inh (strobe f write on the insn_end edge)
# Reset state
S 0 0
R 0 0 0 0
R 4 0 0 0
R 8 0 0 0
# Permanent bank writes, readback and strobe bit 0 clear
W 0 f 5 0 0
R 0 5 0 0
W 0 e 7 0 0
R 0 5 0 0
E 5 0
R 8 5 0 0
# Read-only status and unmapped offset
W 8 f 3 2 0
W c f 3 2 0
R 0 5 0 0
R 4 0 0 0
R 8 5 0 0
R c 0 2 0
# Temporary bank for one instruction
W 4 f a 0 0
S 5 1
R 4 a 0 0
R 8 15 0 0
E a 1
R 8 1a 0 0
E 5 0
R 8 5 0 0
W 4 e 3 0 0
S 5 0
R 4 a 0 0
# Writes on the insn_end edge
C 4 c 0 5 1
R 8 15 0 0
E c 1
E 5 0
C 0 7 0 5 0
E 7 0
R 8 7 0 0
W 4 f 3 0 0
C 4 6 0 3 1
E 6 1
E 7 0
R 8 7 0 0
# Back-pressure on bready and rready
W 0 f 9 0 4
R 0 9 0 5
R c 0 2 3
W c f 1 2 3
E 9 0
R 8 9 0 2
W 4 f b 0 2
R 8 19 0 3
E b 1
E 9 0

/* bench/ucb_tb.sv */
`timescale 1ns/1ns
`include "ucb_settings.svh"

module ucb_tb
   import ucb_pkg::*;
();

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 4;
   localparam int RAND_OPS     = 200;
   localparam int ACCEPT_LIMIT = 16;

   logic                     clk = 1'b0;
   logic                     rst_n;
   ucb_addr_t                awaddr;
   logic                     awvalid;
   logic                     awready;
   ucb_data_t                wdata;
   logic [`UCB_DATA_W/8-1:0] wstrb;
   logic                     wvalid;
   logic                     wready;
   ucb_resp_t                bresp;
   logic                     bvalid;
   logic                     bready;
   ucb_addr_t                araddr;
   logic                     arvalid;
   logic                     arready;
   ucb_data_t                rdata;
   ucb_resp_t                rresp;
   logic                     rvalid;
   logic                     rready;
   logic                     insn_end;
   ucb_bank_t                ucb;
   logic                     irq_inhibit;

   // Reference model of the bank rules
   ucb_bank_t                m_perm;
   ucb_bank_t                m_temp;
   ucb_bank_t                m_ucb;
   logic                     m_pend;
   logic                     m_from_temp;

   string                    stim_q[$];
   string                    test_name = "reset";
   int                       ops_total = 0;
   int                       fail_count = 0;
   logic [31:0]              rnd_state = 32'hb44179f7;

   always #(CLK_PERIOD / 2) clk = ~clk;

   ucb_top DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .insn_end    (insn_end),
      .ucb         (ucb),
      .irq_inhibit (irq_inhibit)
   );

   ////////////////////////////////////////////////////////////
   // Error handling and checks
   ////////////////////////////////////////////////////////////

   task automatic abort_run();
      fail_count++;
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_value(input string what, input logic [35:0] exp,
                              input logic [35:0] act);
      assert (act === exp) else begin
         $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, exp, act);
         abort_run();
      end
   endtask

   task automatic check_true(input string what, input logic cond);
      assert (cond === 1'b1) else begin
         $display("%s: %s", test_name, what);
         abort_run();
      end
   endtask

   task automatic check_outputs(input logic [35:0] exp_ucb, input logic [35:0] exp_inh);
      check_value("ucb", exp_ucb, ucb);
      check_value("irq_inhibit", exp_inh, irq_inhibit);
   endtask

   // LCG with numerical recipes constants
   function automatic logic [31:0] next_random();
      rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
      return rnd_state;
   endfunction

   ////////////////////////////////////////////////////////////
   // AXI4-Lite master
   ////////////////////////////////////////////////////////////

   // Valid bit, response code and data of the waiting response
   function automatic logic [34:0] resp_snapshot(input logic is_read);
      if (is_read) begin
         return {rvalid, rresp, rdata};
      end
      return {bvalid, bresp, 32'h0};
   endfunction

   // Returns just before the accepting edge
   task automatic await_accept(input logic is_read);
      int waited = 0;
      #1;
      while (!(is_read ? arready : (awready && wready))) begin
         @(negedge clk);
         insn_end = 1'b0;
         waited++;
         check_true("AXI request not accepted in time", waited < ACCEPT_LIMIT);
         #1;
      end
   endtask

   task automatic complete_response(input logic is_read, input int hold,
                                    output logic [34:0] snap);
      // Request taken at the edge just passed
      // a harmless new one is offered while the response is stalled
      @(negedge clk);
      insn_end = 1'b0;
      awvalid  = (hold > 0);
      wvalid   = (hold > 0);
      arvalid  = (hold > 0);
      awaddr   = 4'hc;
      wstrb    = 4'h0;
      bready   = (hold == 0);
      rready   = (hold == 0);
      #1;
      snap = resp_snapshot(is_read);
      check_true("response not valid after the request was taken", snap[34]);
      for (int i = 0; i < hold; i++) begin
         check_true("request accepted while a response waits",
                    !awready && !wready && !arready);
         @(negedge clk);
         if (i == hold - 1) begin
            awvalid = 1'b0;
            wvalid  = 1'b0;
            arvalid = 1'b0;
            bready  = 1'b1;
            rready  = 1'b1;
         end
         #1;
         // Each stalled edge leaves the response as it was
         check_value("held response", snap, resp_snapshot(is_read));
      end
      @(negedge clk);
      bready = 1'b0;
      rready = 1'b0;
      #1;
      check_true("response still valid after its ready", !bvalid && !rvalid);
   endtask

   task automatic axi_write(input ucb_addr_t addr, input logic [3:0] strb,
                            input ucb_data_t data, input int hold,
                            input logic with_end, output ucb_resp_t resp);
      logic [34:0] snap;
      @(negedge clk);
      awaddr   = addr;
      wdata    = data;
      wstrb    = strb;
      awvalid  = 1'b1;
      wvalid   = 1'b1;
      // Collision case with the end pulse on the accepting edge
      insn_end = with_end;
      await_accept(1'b0);
      complete_response(1'b0, hold, snap);
      resp = snap[33:32];
   endtask

   task automatic axi_read(input ucb_addr_t addr, input int hold,
                           output ucb_data_t data, output ucb_resp_t resp);
      logic [34:0] snap;
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      await_accept(1'b1);
      complete_response(1'b1, hold, snap);
      data = snap[31:0];
      resp = snap[33:32];
   endtask

   task automatic pulse_end();
      @(negedge clk);
      insn_end = 1'b1;
      @(negedge clk);
      insn_end = 1'b0;
      #1;
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////

   // Output stage takes the selection made before the edge
   task automatic model_end();
      m_ucb       = m_pend ? m_temp : m_perm;
      m_from_temp = m_pend;
      m_pend      = 1'b0;
   endtask

   task automatic model_write(input ucb_addr_t addr, input logic [3:0] strb,
                              input ucb_data_t data, output ucb_resp_t resp);
      resp = RESP_SLVERR;
      if (addr == `UCB_OFS_PERM || addr == `UCB_OFS_TEMP) begin
         resp = RESP_OKAY;
      end
      if (resp == RESP_OKAY && strb[0]) begin
         if (addr == `UCB_OFS_PERM) begin
            m_perm = data[`UCB_BANK_W-1:0];
         end else begin
            m_temp = data[`UCB_BANK_W-1:0];
            m_pend = 1'b1;
         end
      end
   endtask

   // Response code above the read data
   function automatic logic [33:0] model_read(input ucb_addr_t addr);
      case (addr)
         `UCB_OFS_PERM:   return {RESP_OKAY, 28'h0, m_perm};
         `UCB_OFS_TEMP:   return {RESP_OKAY, 28'h0, m_temp};
         `UCB_OFS_STATUS: return {RESP_OKAY, 27'h0, m_pend | m_from_temp, m_ucb};
         default:         return {RESP_SLVERR, 32'h0};
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // Directed and random phases
   ////////////////////////////////////////////////////////////

   task automatic load_stim();
      int    fd;
      string line;
      fd = $fopen("bench/ucb_stim.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file bench/ucb_stim.txt");
         abort_run();
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         // Comments and blank lines skipped
         if (line.len() > 1 && line[0] != "#") begin
            stim_q.push_back(line);
         end
      end
      $fclose(fd);
   endtask

   task automatic run_stim_line(input string line);
      logic [7:0]  op;
      logic [31:0] f0;
      logic [31:0] f1;
      logic [31:0] f2;
      logic [31:0] f3;
      logic [31:0] f4;
      ucb_resp_t   resp;
      ucb_resp_t   ref_resp;
      ucb_data_t   data;
      void'($sscanf(line, "%c %h %h %h %h %h", op, f0, f1, f2, f3, f4));
      case (op)
         "W": begin
            axi_write(f0[3:0], f1[3:0], f2, f4, 1'b0, resp);
            model_write(f0[3:0], f1[3:0], f2, ref_resp);
            check_value("bresp", f3, resp);
         end
         "R": begin
            axi_read(f0[3:0], f3, data, resp);
            check_value("rdata", f1, data);
            check_value("rresp", f2, resp);
         end
         "E": begin
            pulse_end();
            model_end();
            check_outputs(f0, f1);
         end
         "S": check_outputs(f0, f1);
         "C": begin
            axi_write(f0[3:0], 4'hf, f1, 0, 1'b1, resp);
            model_end();
            model_write(f0[3:0], 4'hf, f1, ref_resp);
            check_value("bresp", f2, resp);
            check_outputs(f3, f4);
         end
         default: begin
            $display("Unknown operation in stimulus line: %s", line);
            abort_run();
         end
      endcase
   endtask

   task automatic run_random(input int k);
      logic [31:0] r;
      ucb_data_t   data;
      ucb_addr_t   addr;
      logic [3:0]  strb;
      ucb_resp_t   resp;
      ucb_resp_t   ref_resp;
      ucb_data_t   rd;
      logic [33:0] exp_rd;
      int          hold;
      r         = next_random();
      data      = next_random();
      addr      = {r[9:8], 2'b00};
      hold      = r[13:12];
      strb      = (r[2:0] == 3'd2) ? r[19:16] : 4'hf;
      test_name = $sformatf("random op %0d", k);
      if (r[2:0] == 3'd0) begin
         addr = `UCB_OFS_PERM;
      end else if (r[2:0] == 3'd1) begin
         addr = `UCB_OFS_TEMP;
      end
      case (r[2:0])
         3'd0, 3'd1, 3'd2, 3'd7: begin
            axi_write(addr, strb, data, hold, r[2:0] == 3'd7, resp);
            if (r[2:0] == 3'd7) begin
               model_end();
            end
            model_write(addr, strb, data, ref_resp);
            check_value("bresp", ref_resp, resp);
         end
         3'd3, 3'd4: begin
            exp_rd = model_read(addr);
            axi_read(addr, hold, rd, resp);
            check_value("rdata", exp_rd[31:0], rd);
            check_value("rresp", exp_rd[33:32], resp);
         end
         default: begin
            pulse_end();
            model_end();
         end
      endcase
      check_outputs(m_ucb, m_pend | m_from_temp);
   endtask

   initial begin
      rst_n       = 1'b0;
      insn_end    = 1'b0;
      awaddr      = '0;
      awvalid     = 1'b0;
      wdata       = '0;
      wstrb       = '0;
      wvalid      = 1'b0;
      bready      = 1'b0;
      araddr      = '0;
      arvalid     = 1'b0;
      rready      = 1'b0;
      m_perm      = '0;
      m_temp      = '0;
      m_ucb       = '0;
      m_pend      = 1'b0;
      m_from_temp = 1'b0;
      load_stim();
      ops_total = stim_q.size() + RAND_OPS;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      foreach (stim_q[i]) begin
         test_name = $sformatf("stim op %0d", i);
         run_stim_line(stim_q[i]);
      end
      for (int k = 0; k < RAND_OPS; k++) begin
         run_random(k);
      end
      if (fail_count == 0) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         abort_run();
      end
   end

   // Bound assertion failures end the run as well
   initial begin
      wait (DUT.u_asserts.error_count != 0);
      $display("A bound protocol or pipeline assertion failed");
      abort_run();
   end

   // Watchdog allowing 20 cycles per operation plus reset
   initial begin
      wait (ops_total > 0);
      #((ops_total * 20 + RESET_CYCLES) * CLK_PERIOD);
      $display("Watchdog timeout: tests did not finish in %0d cycles",
               ops_total * 20 + RESET_CYCLES);
      abort_run();
   end

endmodule

/* filelist.f */
+incdir+include
rtl/ucb_pkg.sv
rtl/ucb_axil_decode.sv
rtl/ucb_bank_exec.sv
rtl/ucb_bank_result.sv
rtl/ucb_top.sv
bench/ucb_asserts.sv
bench/ucb_tb.sv

/* include/ucb_settings.svh */
`ifndef UCB_SETTINGS_SVH
`define UCB_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////

// AXI4-Lite address width covering four word registers
`define UCB_ADDR_W 4

// AXI4-Lite data width
`define UCB_DATA_W 32

// Microcode bank number width
`define UCB_BANK_W 4

////////////////////////////////////////////////////////////
// Register map in byte offsets
////////////////////////////////////////////////////////////

// Permanent bank for read and write
`define UCB_OFS_PERM 4'h0
// Temporary bank for read and write
`define UCB_OFS_TEMP 4'h4
// Read-only status word
`define UCB_OFS_STATUS 4'h8

`endif

/* rtl/ucb_axil_decode.sv */
`timescale 1ns/1ns
`include "ucb_settings.svh"

module ucb_axil_decode
   import ucb_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   // Write address channel
   input  ucb_addr_t                 awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   // Write data channel
   input  ucb_data_t                 wdata,
   input  logic [`UCB_DATA_W/8-1:0]  wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   // Write response channel
   output ucb_resp_t                 bresp,
   output logic                      bvalid,
   input  logic                      bready,
   // Read address channel
   input  ucb_addr_t                 araddr,
   input  logic                      arvalid,
   output logic                      arready,
   // Read data channel
   output ucb_data_t                 rdata,
   output ucb_resp_t                 rresp,
   output logic                      rvalid,
   input  logic                      rready,
   // Bank state for reads
   input  ucb_status_t               status,
   // Bank write command
   output ucb_cmd_t                  cmd
);

   ucb_axi_state_e state;
   logic           wr_accept;
   logic           rd_accept;
   ucb_resp_t      wr_resp;
   ucb_resp_t      rd_resp;
   ucb_data_t      rd_data;

   ////////////////////////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////////////////////////

   // Address and data are taken together and writes go before reads
   assign wr_accept = (state == AXI_IDLE) && awvalid && wvalid;
   assign rd_accept = (state == AXI_IDLE) && arvalid && !(awvalid && wvalid);

   assign awready = wr_accept;
   assign wready  = wr_accept;
   assign arready = rd_accept;

   // Responses held by the FSM state itself
   assign bvalid = (state == AXI_WRESP);
   assign rvalid = (state == AXI_RDATA);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= AXI_IDLE;
      end else begin
         case (state)
            AXI_IDLE: begin
               if (wr_accept) begin
                  state <= AXI_WRESP;
               end else if (rd_accept) begin
                  state <= AXI_RDATA;
               end
            end
            // Wait for the master to take the response
            AXI_WRESP: begin
               if (bready) begin
                  state <= AXI_IDLE;
               end
            end
            AXI_RDATA: begin
               if (rready) begin
                  state <= AXI_IDLE;
               end
            end
            default: begin
               state <= AXI_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      cmd          = '0;
      cmd.bank     = wdata[`UCB_BANK_W-1:0];
      wr_resp      = RESP_OKAY;
      case (awaddr)
         // Low byte strobe gates the load and the response stays OKAY
         `UCB_OFS_PERM: cmd.set_perm = wr_accept && wstrb[0];
         `UCB_OFS_TEMP: cmd.set_temp = wr_accept && wstrb[0];
         // Status is read only and the rest is unmapped
         default:       wr_resp = RESP_SLVERR;
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Read decode
   ////////////////////////////////////////////////////////////

   always_comb begin
      rd_data = '0;
      rd_resp = RESP_OKAY;
      case (araddr)
         `UCB_OFS_PERM: rd_data[`UCB_BANK_W-1:0] = status.perm_bank;
         `UCB_OFS_TEMP: rd_data[`UCB_BANK_W-1:0] = status.temp_bank;
         `UCB_OFS_STATUS: begin
            // Current bank low with the inhibit flag just above it
            rd_data[`UCB_BANK_W-1:0] = status.cur_bank;
            rd_data[`UCB_BANK_W]     = status.inhibit;
         end
         default: rd_resp = RESP_SLVERR;
      endcase
   end

   // Response payload captured at acceptance and held while valid
   always_ff @(posedge clk) begin
      if (wr_accept) begin
         bresp <= wr_resp;
      end
      if (rd_accept) begin
         rdata <= rd_data;
         rresp <= rd_resp;
      end
   end

endmodule

/* rtl/ucb_bank_exec.sv */
`timescale 1ns/1ns

module ucb_bank_exec
   import ucb_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   // Write command from the register decoder
   input  ucb_cmd_t  cmd,
   // End of the current instruction
   input  logic      insn_end,
   // Bank for the next instruction
   output ucb_bank_t next_bank,
   // Temporary bank waiting for the next instruction
   output logic      pending,
   // Register contents for status
   output ucb_bank_t perm_bank,
   output ucb_bank_t temp_bank
);

   ////////////////////////////////////////////////////////////
   // Bank registers
   ////////////////////////////////////////////////////////////

   // Both load at the edge that accepts the write
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         perm_bank <= '0;
         temp_bank <= '0;
      end else begin
         if (cmd.set_perm) begin
            perm_bank <= cmd.bank;
         end
         if (cmd.set_temp) begin
            temp_bank <= cmd.bank;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Temporary bank sequencer
   ////////////////////////////////////////////////////////////

   // Set by a temporary write and cleared by the next instruction end
   // A write in the same cycle as the end keeps it set
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending <= 1'b0;
      end else if (cmd.set_temp) begin
         pending <= 1'b1;
      end else if (insn_end) begin
         pending <= 1'b0;
      end
   end

   // Bank mux
   // Temporary bank for exactly one instruction and then permanent again
   assign next_bank = pending ? temp_bank : perm_bank;

endmodule

/* rtl/ucb_bank_result.sv */
`timescale 1ns/1ns

module ucb_bank_result
   import ucb_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   // End of the current instruction
   input  logic        insn_end,
   // Selection from the bank sequencer
   input  ucb_bank_t   next_bank,
   input  logic        pending,
   // Register contents passed through to status
   input  ucb_bank_t   perm_bank,
   input  ucb_bank_t   temp_bank,
   // Current microcode bank
   output ucb_bank_t   ucb,
   // Interrupts held off around a temporary bank
   output logic        irq_inhibit,
   // Readable state
   output ucb_status_t status
);

   // Current bank came from the temporary register
   logic from_temp;

   ////////////////////////////////////////////////////////////
   // Output bank register
   ////////////////////////////////////////////////////////////

   // Delays the selection by one instruction
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ucb       <= '0;
         from_temp <= 1'b0;
      end else if (insn_end) begin
         ucb       <= next_bank;
         from_temp <= pending;
      end
   end

   // High from the temporary write until the permanent bank is back
   assign irq_inhibit = pending | from_temp;

   ////////////////////////////////////////////////////////////
   // Status word
   ////////////////////////////////////////////////////////////

   always_comb begin
      status.perm_bank = perm_bank;
      status.temp_bank = temp_bank;
      status.cur_bank  = ucb;
      status.inhibit   = irq_inhibit;
   end

endmodule

/* rtl/ucb_pkg.sv */
`include "ucb_settings.svh"

package ucb_pkg;

   ////////////////////////////////////////////////////////////
   // Plain vector types
   ////////////////////////////////////////////////////////////

   // Microcode bank number
   typedef logic [`UCB_BANK_W-1:0] ucb_bank_t;

   // AXI4-Lite address and data
   typedef logic [`UCB_ADDR_W-1:0] ucb_addr_t;
   typedef logic [`UCB_DATA_W-1:0] ucb_data_t;

   // AXI response code
   typedef logic [1:0] ucb_resp_t;

   // Response codes used by the slave
   localparam ucb_resp_t RESP_OKAY   = 2'b00;
   localparam ucb_resp_t RESP_SLVERR = 2'b10;

   ////////////////////////////////////////////////////////////
   // Structs between the blocks
   ////////////////////////////////////////////////////////////

   // Bank write command from the register decoder
   // Strobes last only for the accepting cycle
   typedef struct packed {
      logic      set_perm;
      logic      set_temp;
      ucb_bank_t bank;
   } ucb_cmd_t;

   // Readable state of the bank logic
   typedef struct packed {
      ucb_bank_t perm_bank;
      ucb_bank_t temp_bank;
      ucb_bank_t cur_bank;
      logic      inhibit;
   } ucb_status_t;

   // AXI slave FSM with at most one transaction in flight
   typedef enum logic [1:0] {
      AXI_IDLE,
      AXI_WRESP,
      AXI_RDATA
   } ucb_axi_state_e;

endpackage

/* rtl/ucb_top.sv */
`timescale 1ns/1ns
`include "ucb_settings.svh"

module ucb_top
   import ucb_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   // AXI4-Lite slave
   input  ucb_addr_t                 awaddr,
   input  logic                      awvalid,
   output logic                      awready,
   input  ucb_data_t                 wdata,
   input  logic [`UCB_DATA_W/8-1:0]  wstrb,
   input  logic                      wvalid,
   output logic                      wready,
   output ucb_resp_t                 bresp,
   output logic                      bvalid,
   input  logic                      bready,
   input  ucb_addr_t                 araddr,
   input  logic                      arvalid,
   output logic                      arready,
   output ucb_data_t                 rdata,
   output ucb_resp_t                 rresp,
   output logic                      rvalid,
   input  logic                      rready,
   // Sequencer side
   input  logic                      insn_end,
   output ucb_bank_t                 ucb,
   output logic                      irq_inhibit
);

   // Decoder to sequencer
   ucb_cmd_t    cmd;
   // Sequencer to output stage
   ucb_bank_t   next_bank;
   logic        pending;
   ucb_bank_t   perm_bank;
   ucb_bank_t   temp_bank;
   // Output stage back to decoder
   ucb_status_t status;

   ////////////////////////////////////////////////////////////
   // Register decoder
   ////////////////////////////////////////////////////////////

   ucb_axil_decode u_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready),
      .status  (status),
      .cmd     (cmd)
   );

   // Bank registers and temporary sequencer
   ucb_bank_exec u_exec (
      .clk       (clk),
      .rst_n     (rst_n),
      .cmd       (cmd),
      .insn_end  (insn_end),
      .next_bank (next_bank),
      .pending   (pending),
      .perm_bank (perm_bank),
      .temp_bank (temp_bank)
   );

   // Output bank, inhibit and status
   ucb_bank_result u_result (
      .clk         (clk),
      .rst_n       (rst_n),
      .insn_end    (insn_end),
      .next_bank   (next_bank),
      .pending     (pending),
      .perm_bank   (perm_bank),
      .temp_bank   (temp_bank),
      .ucb         (ucb),
      .irq_inhibit (irq_inhibit),
      .status      (status)
   );

endmodule
